// File: hdl/tile_layer_pkg.sv
/* tile layer types for map words, ROM and line buffer widths, scanner states */
package tile_layer_pkg;

  typedef logic [11:0] tile_code_t;
  typedef logic [3:0]  tile_color_t;
  // color bank in the high nibble, pixel nibble in the low one
  typedef logic [7:0]  pix_index_t;
  typedef logic [9:0]  map_addr_t;
  typedef logic [17:0] gfx_addr_t;
  typedef logic [8:0]  scroll_t;
  typedef logic [7:0]  line_t;
  typedef logic [11:0] rgb_t;
  typedef logic [10:0] cpu_addr_t;

  typedef enum logic [2:0] {
    st_start,
    st_wait_decode,
    st_fetch_rom,
    st_copy_rom,
    st_wait_pixel,
    st_copy_pixel,
    st_finished
  } scan_state_t;

  localparam pix_index_t TRANSPARENT_INDEX = 8'h0F;

endpackage

// File: hdl/video_timing_pkg.sv
/* beam counter types and default frame timing */
package video_timing_pkg;

  typedef logic [10:0] hcount_t;
  typedef logic [8:0]  vcount_t;

  // clocks per line at the core clock
  localparam int H_TOTAL_DEFAULT   = 1536;
  localparam int V_TOTAL_DEFAULT   = 262;
  localparam int V_VISIBLE_DEFAULT = 224;

endpackage

// File: hdl/video_timing.sv
/* beam counters, visible area, frame start and the line to render next */
`timescale 1ns/1ps

module video_timing #(
  parameter int H_TOTAL   = video_timing_pkg::H_TOTAL_DEFAULT,
  parameter int V_TOTAL   = video_timing_pkg::V_TOTAL_DEFAULT,
  parameter int V_VISIBLE = video_timing_pkg::V_VISIBLE_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst,
  output video_timing_pkg::hcount_t hcount,
  output video_timing_pkg::vcount_t vcount,
  output logic                      visible,
  output logic                      frame_start,
  output tile_layer_pkg::line_t     render_line
);
  import video_timing_pkg::*;
  import tile_layer_pkg::*;

  localparam int      H_VISIBLE = 256;
  localparam hcount_t H_LAST    = hcount_t'(H_TOTAL - 1);
  localparam hcount_t H_VIS     = hcount_t'(H_VISIBLE);
  localparam vcount_t V_LAST    = vcount_t'(V_TOTAL - 1);
  localparam vcount_t V_VIS     = vcount_t'(V_VISIBLE);

  logic    h_wrap;
  vcount_t next_v;

  assign h_wrap = (hcount == H_LAST);
  assign next_v = (vcount == V_LAST) ? '0 : vcount + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (h_wrap) begin
      hcount <= '0;
      vcount <= next_v;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  assign visible = (hcount < H_VIS) && (vcount < V_VIS);

  // scanner works one line ahead of the beam
  assign render_line = line_t'(next_v);

  // render side wraps to line 0 here, one line before the display does,
  // so line 0 is already built with the new frame's scroll values
  assign frame_start = (hcount == '0) && (vcount == V_LAST);

endmodule

// File: hdl/layer_cpu_if.sv
/* CPU write decode for tile map and palette, scroll registers with frame shadows */
`timescale 1ns/1ps

module layer_cpu_if (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cpu_we,
  input  tile_layer_pkg::cpu_addr_t  cpu_addr,
  input  logic [15:0]                cpu_wdata,
  input  logic                       frame_start,
  output logic                       map_we,
  output tile_layer_pkg::map_addr_t  map_waddr,
  output logic [15:0]                map_wdata,
  output logic                       pal_we,
  output tile_layer_pkg::pix_index_t pal_waddr,
  output tile_layer_pkg::rgb_t       pal_wdata,
  output tile_layer_pkg::scroll_t    scroll_x,
  output tile_layer_pkg::scroll_t    scroll_y
);
  import tile_layer_pkg::*;

  localparam cpu_addr_t SCROLL_X_ADDR = 11'h400;
  localparam cpu_addr_t SCROLL_Y_ADDR = 11'h401;

  logic    sel_map;
  logic    sel_pal;
  scroll_t scroll_x_reg;
  scroll_t scroll_y_reg;

  // map at 0x000-0x3ff, palette at 0x500-0x5ff
  assign sel_map = ~cpu_addr[10];
  assign sel_pal = (cpu_addr[10:8] == 3'b101);

  assign map_we    = cpu_we & sel_map;
  assign map_waddr = map_addr_t'(cpu_addr[9:0]);
  assign map_wdata = cpu_wdata;
  assign pal_we    = cpu_we & sel_pal;
  assign pal_waddr = pix_index_t'(cpu_addr[7:0]);
  assign pal_wdata = rgb_t'(cpu_wdata[11:0]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scroll_x_reg <= '0;
      scroll_y_reg <= '0;
      scroll_x     <= '0;
      scroll_y     <= '0;
    end else begin
      if (cpu_we && cpu_addr == SCROLL_X_ADDR) begin
        scroll_x_reg <= scroll_t'(cpu_wdata[8:0]);
      end
      if (cpu_we && cpu_addr == SCROLL_Y_ADDR) begin
        scroll_y_reg <= scroll_t'(cpu_wdata[8:0]);
      end
      // scanner only ever sees values copied at a frame boundary
      if (frame_start) begin
        scroll_x <= scroll_x_reg;
        scroll_y <= scroll_y_reg;
      end
    end
  end

endmodule

// File: hdl/tile_map_ram.sv
/* 1024x16 tile map, CPU write port and registered scanner read port */
`timescale 1ns/1ps

module tile_map_ram (
  input  logic                      clk,
  input  logic                      map_we,
  input  tile_layer_pkg::map_addr_t map_waddr,
  input  logic [15:0]               map_wdata,
  input  tile_layer_pkg::map_addr_t scan_addr,
  output logic [15:0]               scan_data
);

  // word layout is color bank in [15:12], tile code in [11:0]
  logic [15:0] mem [1024];

  always_ff @(posedge clk) begin
    if (map_we) begin
      mem[map_waddr] <= map_wdata;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    scan_data <= mem[scan_addr];
  end

endmodule

// File: hdl/tile_line_scanner.sv
/* line scanner: tile map walk, graphics ROM fetch, 4bpp decode
   and the two-bank 256 pixel line buffer */
`timescale 1ns/1ps

module tile_line_scanner (
  input  logic                       clk,
  input  logic                       rst,
  input  tile_layer_pkg::line_t      line_number,
  output tile_layer_pkg::map_addr_t  ram_addr,
  input  logic [15:0]                ram_out,
  input  logic [15:0]                gfx_rom_data,
  input  logic                       gfx_rom_ok,
  output tile_layer_pkg::gfx_addr_t  gfx_rom_addr,
  output logic                       gfx_rom_cs,
  input  tile_layer_pkg::scroll_t    scroll_x,
  input  tile_layer_pkg::scroll_t    scroll_y,
  input  logic                       line_buffer_bank,
  input  logic [7:0]                 line_buffer_addr,
  output tile_layer_pkg::pix_index_t line_buffer_out
);
  import tile_layer_pkg::*;

  scan_state_t state;
  line_t       line_q;
  scroll_t     vy_q;
  logic [4:0]  tile_x_q;
  logic [1:0]  word_idx;
  logic [3:0]  pix_col;
  logic [7:0]  lb_index;
  tile_color_t color_q;

  logic [15:0] rom_words [4];
  pix_index_t  line_buffer [2][256];

  scroll_t     start_vy;
  tile_code_t  tile_code;
  logic [15:0] cur_word;
  logic [1:0]  bit_sel;
  logic [3:0]  nibble;
  pix_index_t  lb_wdata;
  logic        lb_we;

  // virtual row wraps at 512
  assign start_vy  = scroll_t'({1'b0, line_number}) + scroll_y;
  assign tile_code = ram_out[11:0];

  // 4 columns per ROM word, one bit per plane
  assign cur_word = rom_words[pix_col[3:2]];
  assign bit_sel  = pix_col[1:0];
  assign nibble   = {cur_word[{2'b11, bit_sel}], cur_word[{2'b10, bit_sel}],
                     cur_word[{2'b01, bit_sel}], cur_word[{2'b00, bit_sel}]};
  assign lb_wdata = (nibble == 4'hF) ? TRANSPARENT_INDEX : {color_q, nibble};
  assign lb_we    = (state == st_copy_pixel);

  assign line_buffer_out = line_buffer[line_buffer_bank][line_buffer_addr];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= st_finished;
      line_q       <= '0;
      vy_q         <= '0;
      tile_x_q     <= '0;
      word_idx     <= '0;
      pix_col      <= '0;
      lb_index     <= '0;
      color_q      <= '0;
      ram_addr     <= '0;
      gfx_rom_addr <= '0;
      gfx_rom_cs   <= 1'b0;
    end else begin
      case (state)
        st_start: begin
          line_q   <= line_number;
          vy_q     <= start_vy;
          ram_addr <= {start_vy[8:4], scroll_x[8:4]};
          tile_x_q <= scroll_x[8:4] + 5'd1;
          // first tile is entered part way through
          pix_col  <= scroll_x[3:0];
          lb_index <= '0;
          word_idx <= '0;
          state    <= st_wait_decode;
        end

        st_wait_decode: begin
          state <= st_fetch_rom;
        end

        st_fetch_rom: begin
          // code*64 + row*2 + word[0], plus 32 for words 2 and 3
          gfx_rom_addr <= {tile_code, word_idx[1], vy_q[3:0], word_idx[0]};
          gfx_rom_cs   <= 1'b1;
          state        <= st_copy_rom;
        end

        st_copy_rom: begin
          if (gfx_rom_ok) begin
            gfx_rom_cs <= 1'b0;
            if (word_idx == 2'd3) begin
              state <= st_wait_pixel;
            end else begin
              word_idx <= word_idx + 2'd1;
              state    <= st_fetch_rom;
            end
          end
        end

        st_wait_pixel: begin
          color_q  <= ram_out[15:12];
          // map word of the next tile is read while this one is drawn
          ram_addr <= {vy_q[8:4], tile_x_q};
          tile_x_q <= tile_x_q + 5'd1;
          state    <= st_copy_pixel;
        end

        st_copy_pixel: begin
          lb_index <= lb_index + 8'd1;
          pix_col  <= pix_col + 4'd1;
          if (lb_index == 8'd255) begin
            state <= st_finished;
          end else if (pix_col == 4'd15) begin
            word_idx <= '0;
            state    <= st_fetch_rom;
          end
        end

        st_finished: begin
          if (line_number != line_q) begin
            state <= st_start;
          end
        end

        default: begin
          state <= st_finished;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_copy_rom && gfx_rom_ok) begin
      rom_words[word_idx] <= gfx_rom_data;
    end
  end

  // even lines go to bank 0, odd lines to bank 1
  always_ff @(posedge clk) begin
    if (lb_we) begin
      line_buffer[line_q[0]][lb_index] <= lb_wdata;
    end
  end

endmodule

// File: hdl/palette_out.sv
/* line buffer readout, 256-entry palette RAM and registered pixel output */
`timescale 1ns/1ps

module palette_out (
  input  logic                       clk,
  input  logic                       rst,
  input  video_timing_pkg::hcount_t  hcount,
  input  video_timing_pkg::vcount_t  vcount,
  input  logic                       visible,
  output logic                       lb_bank,
  output logic [7:0]                 lb_addr,
  input  tile_layer_pkg::pix_index_t lb_data,
  input  logic                       pal_we,
  input  tile_layer_pkg::pix_index_t pal_waddr,
  input  tile_layer_pkg::rgb_t       pal_wdata,
  output logic                       pixel_valid,
  output logic [7:0]                 pixel_x,
  output video_timing_pkg::vcount_t  pixel_y,
  output tile_layer_pkg::pix_index_t pixel_index,
  output tile_layer_pkg::rgb_t       pixel_rgb,
  output logic                       pixel_opaque
);
  import video_timing_pkg::*;
  import tile_layer_pkg::*;

  rgb_t       palette [256];
  logic       valid_q;
  logic [7:0] x_q;
  vcount_t    y_q;
  pix_index_t index_q;

  // display reads the bank the scanner filled during the previous line
  assign lb_bank = vcount[0];
  assign lb_addr = hcount[7:0];

  always_ff @(posedge clk) begin
    if (pal_we) begin
      palette[pal_waddr] <= pal_wdata;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q     <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      valid_q     <= visible;
      pixel_valid <= valid_q;
    end
  end

  // stage 1 holds the index, stage 2 the palette lookup
  always_ff @(posedge clk) begin
    index_q      <= lb_data;
    x_q          <= hcount[7:0];
    y_q          <= vcount;
    pixel_index  <= index_q;
    pixel_x      <= x_q;
    pixel_y      <= y_q;
    pixel_rgb    <= palette[index_q];
    pixel_opaque <= (index_q != TRANSPARENT_INDEX);
  end

endmodule

// File: hdl/tile_layer_top.sv
/* background tile layer top: timing, CPU port, tile map, scanner and palette */
`timescale 1ns/1ps

module tile_layer_top #(
  parameter int H_TOTAL   = video_timing_pkg::H_TOTAL_DEFAULT,
  parameter int V_TOTAL   = video_timing_pkg::V_TOTAL_DEFAULT,
  parameter int V_VISIBLE = video_timing_pkg::V_VISIBLE_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cpu_we,
  input  tile_layer_pkg::cpu_addr_t  cpu_addr,
  input  logic [15:0]                cpu_wdata,
  output logic                       gfx_rom_cs,
  output tile_layer_pkg::gfx_addr_t  gfx_rom_addr,
  input  logic [15:0]                gfx_rom_data,
  input  logic                       gfx_rom_ok,
  output logic                       pixel_valid,
  output logic [7:0]                 pixel_x,
  output video_timing_pkg::vcount_t  pixel_y,
  output tile_layer_pkg::pix_index_t pixel_index,
  output tile_layer_pkg::rgb_t       pixel_rgb,
  output logic                       pixel_opaque
);
  import video_timing_pkg::*;
  import tile_layer_pkg::*;

  hcount_t     hcount;
  vcount_t     vcount;
  logic        visible;
  logic        frame_start;
  line_t       render_line;
  logic        map_we;
  map_addr_t   map_waddr;
  logic [15:0] map_wdata;
  logic        pal_we;
  pix_index_t  pal_waddr;
  rgb_t        pal_wdata;
  scroll_t     scroll_x;
  scroll_t     scroll_y;
  map_addr_t   scan_addr;
  logic [15:0] scan_data;
  logic        lb_bank;
  logic [7:0]  lb_addr;
  pix_index_t  lb_data;

  video_timing #(
    .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .V_VISIBLE(V_VISIBLE)
  ) u_video_timing (
    .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .visible(visible),
    .frame_start(frame_start), .render_line(render_line)
  );

  layer_cpu_if u_layer_cpu_if (
    .clk(clk), .rst(rst), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .frame_start(frame_start),
    .map_we(map_we), .map_waddr(map_waddr), .map_wdata(map_wdata),
    .pal_we(pal_we), .pal_waddr(pal_waddr), .pal_wdata(pal_wdata),
    .scroll_x(scroll_x), .scroll_y(scroll_y)
  );

  tile_map_ram u_tile_map_ram (
    .clk(clk), .map_we(map_we), .map_waddr(map_waddr), .map_wdata(map_wdata),
    .scan_addr(scan_addr), .scan_data(scan_data)
  );

  tile_line_scanner u_tile_line_scanner (
    .clk(clk), .rst(rst), .line_number(render_line),
    .ram_addr(scan_addr), .ram_out(scan_data),
    .gfx_rom_data(gfx_rom_data), .gfx_rom_ok(gfx_rom_ok),
    .gfx_rom_addr(gfx_rom_addr), .gfx_rom_cs(gfx_rom_cs),
    .scroll_x(scroll_x), .scroll_y(scroll_y),
    .line_buffer_bank(lb_bank), .line_buffer_addr(lb_addr), .line_buffer_out(lb_data)
  );

  palette_out u_palette_out (
    .clk(clk), .rst(rst), .hcount(hcount), .vcount(vcount), .visible(visible),
    .lb_bank(lb_bank), .lb_addr(lb_addr), .lb_data(lb_data),
    .pal_we(pal_we), .pal_waddr(pal_waddr), .pal_wdata(pal_wdata),
    .pixel_valid(pixel_valid), .pixel_x(pixel_x), .pixel_y(pixel_y),
    .pixel_index(pixel_index), .pixel_rgb(pixel_rgb), .pixel_opaque(pixel_opaque)
  );

endmodule

// File: bench/tile_layer_props.sv
/* scanner assertions: ROM request hold, request idle around reset,
   line finished before the next line number */
`timescale 1ns/1ps

module tile_layer_props (
  input logic                        clk,
  input logic                        rst,
  input tile_layer_pkg::line_t       line_number,
  input logic                        gfx_rom_cs,
  input tile_layer_pkg::gfx_addr_t   gfx_rom_addr,
  input logic                        gfx_rom_ok,
  input tile_layer_pkg::scan_state_t state
);
  import tile_layer_pkg::*;

  int violations = 0;

  // request and address hold until the ROM answers
  hold_until_ok: assert property (@(posedge clk) disable iff (rst)
    gfx_rom_cs && !gfx_rom_ok |=> gfx_rom_cs && $stable(gfx_rom_addr))
  else begin
    $error("ROM request dropped or address changed before ok");
    violations++;
  end

  drop_after_ok: assert property (@(posedge clk) disable iff (rst)
    gfx_rom_cs && gfx_rom_ok |=> !gfx_rom_cs)
  else begin
    $error("ROM request still high after ok");
    violations++;
  end

  idle_after_reset: assert property (@(posedge clk)
    rst || $past(rst) |-> !gfx_rom_cs)
  else begin
    $error("ROM request active during or right after reset");
    violations++;
  end

  // a new line number must find the previous line done
  done_before_next_line: assert property (@(posedge clk) disable iff (rst)
    $changed(line_number) |-> state == st_finished)
  else begin
    $error("line number changed before the scanner finished");
    violations++;
  end

endmodule

bind tile_line_scanner tile_layer_props u_tile_layer_props (
  .clk(clk), .rst(rst), .line_number(line_number), .gfx_rom_cs(gfx_rom_cs),
  .gfx_rom_addr(gfx_rom_addr), .gfx_rom_ok(gfx_rom_ok), .state(state)
);

// File: bench/tile_layer_tb.sv
/* tile layer testbench: clock, reset, CPU writes, ROM model,
   reference model and pixel checks */
`timescale 1ns/1ps

module tile_layer_tb;
  import tile_layer_pkg::*;
  import video_timing_pkg::*;

  localparam int WAIT_LIMIT = 40000;
  localparam int V_TOTAL    = 8;
  localparam int V_VISIBLE  = 4;

  logic        clk = 1'b0;
  logic        rst;
  logic        cpu_we;
  cpu_addr_t   cpu_addr;
  logic [15:0] cpu_wdata;
  logic        gfx_rom_cs;
  gfx_addr_t   gfx_rom_addr;
  logic [15:0] gfx_rom_data;
  logic        gfx_rom_ok;
  logic        pixel_valid;
  logic [7:0]  pixel_x;
  vcount_t     pixel_y;
  pix_index_t  pixel_index;
  rgb_t        pixel_rgb;
  logic        pixel_opaque;

  integer      seed;
  logic [15:0] ref_map [1024];
  rgb_t        ref_pal [256];
  int          pend_sx = 0;
  int          pend_sy = 0;
  int          cur_sx = 0;
  int          cur_sy = 0;
  int          frame_count = 0;
  int          check_from = 32'h7FFF_FFFF;
  int          checked = 0;
  int          clear_seen = 0;
  // clock edges since reset release, equal to the beam position
  int          beat = 0;

  tile_layer_top #(.V_TOTAL(V_TOTAL), .V_VISIBLE(V_VISIBLE)) u_tile_layer_top (.*);

  always #2 clk = ~clk;

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  // graphics data is a fixed scramble, code 0xfff is all ones
  function automatic logic [15:0] rom_word(input gfx_addr_t addr);
    logic [31:0] mix;
    if (addr[17:6] == 12'hFFF) begin
      return 16'hFFFF;
    end
    mix = {14'h0, addr} * 32'h9E3779B1;
    return mix[31:16] ^ mix[15:0];
  endfunction

  function automatic pix_index_t expect_index(input int x, input int y);
    int          vx;
    int          vy;
    int          col;
    logic [15:0] mword;
    gfx_addr_t   waddr;
    logic [15:0] w;
    logic [3:0]  n;
    vx    = (x + cur_sx) % 512;
    vy    = (y + cur_sy) % 512;
    mword = ref_map[((vy / 16) * 32 + vx / 16) % 1024];
    col   = vx % 16;
    // words 2 and 3 sit 32 words above words 0 and 1
    waddr = gfx_addr_t'(mword[11:0] * 64 + (vy % 16) * 2 + (col / 4) % 2 + (col / 8) * 32);
    w     = rom_word(waddr);
    n     = {w[12 + col % 4], w[8 + col % 4], w[4 + col % 4], w[col % 4]};
    if (n == 4'hF) begin
      return 8'h0F;
    end
    return {mword[15:12], n};
  endfunction

  task automatic cpu_write(input cpu_addr_t addr, input logic [15:0] data);
    cpu_we    = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = data;
    if (addr < 11'h400) begin
      ref_map[addr[9:0]] = data;
    end else if (addr == 11'h400) begin
      pend_sx = data[8:0];
    end else if (addr == 11'h401) begin
      pend_sy = data[8:0];
    end else if (addr[10:8] == 3'b101) begin
      ref_pal[addr[7:0]] = data[11:0];
    end
    @(posedge clk);
    #1;
    cpu_we = 1'b0;
  endtask

  task automatic load_map();
    logic [15:0] word;
    for (int i = 0; i < 1024; i++) begin
      word = {4'(i ^ (i >> 5)), 12'(i * 12'h2B7 + 12'h015)};
      // every seventh tile is fully transparent
      if (i % 7 == 3) begin
        word[11:0] = 12'hFFF;
      end
      cpu_write(cpu_addr_t'(i), word);
    end
  endtask

  task automatic load_palette(input int salt);
    for (int i = 0; i < 256; i++) begin
      cpu_write(cpu_addr_t'(11'h500 + i), 16'((i * 16'h0159 + salt) & 16'h0FFF));
    end
  endtask

  task automatic wait_frame(input int target);
    int n;
    n = 0;
    while (frame_count < target) begin
      @(posedge clk);
      #1;
      n++;
      if (n > WAIT_LIMIT) begin
        report_problem("timeout waiting for the start of a frame");
      end
    end
  endtask

  task automatic wait_line(input vcount_t y);
    int n;
    n = 0;
    while (pixel_y !== y) begin
      @(posedge clk);
      #1;
      n++;
      if (n > WAIT_LIMIT) begin
        report_problem("timeout waiting for a display line");
      end
    end
  endtask

  // ROM answers each request once after 1 to 8 cycles
  initial begin : rom_model
    int delay;
    gfx_rom_ok   = 1'b0;
    gfx_rom_data = '0;
    forever begin
      @(posedge clk);
      #1;
      gfx_rom_ok = 1'b0;
      if (gfx_rom_cs) begin
        delay = 1 + ({$random(seed)} % 8);
        repeat (delay) @(posedge clk);
        #1;
        gfx_rom_data = rom_word(gfx_rom_addr);
        gfx_rom_ok   = 1'b1;
      end
    end
  end

  always @(posedge clk) begin : count_beats
    if (rst) begin
      beat <= 0;
    end else begin
      beat <= beat + 1;
    end
  end

  // pixel outputs trail the beam by 2 cycles
  always @(negedge clk) begin : check_pixels
    pix_index_t exp;
    int         pos;
    int         ex;
    int         ey;
    logic       exp_valid;
    pos       = beat - 2;
    ex        = 0;
    ey        = 0;
    exp_valid = 1'b0;
    if (pos >= 0) begin
      ex        = pos % H_TOTAL_DEFAULT;
      ey        = (pos / H_TOTAL_DEFAULT) % V_TOTAL;
      exp_valid = (ex < 256) && (ey < V_VISIBLE);
    end
    assert (pixel_valid === exp_valid) else report_mismatch($sformatf(
      "pixel_valid %b, expected %b", pixel_valid, exp_valid));
    if (exp_valid) begin
      assert (pixel_x === 8'(ex) && pixel_y === vcount_t'(ey)) else report_mismatch(
        $sformatf("pixel at (%0d,%0d), expected (%0d,%0d)", pixel_x, pixel_y, ex, ey));
      if (ex == 0 && ey == 0) begin
        frame_count++;
        cur_sx = pend_sx;
        cur_sy = pend_sy;
      end
      if (frame_count >= check_from) begin
        exp = expect_index(ex, ey);
        assert (pixel_index === exp) else report_mismatch($sformatf(
          "pixel (%0d,%0d) index %h, expected %h", ex, ey, pixel_index, exp));
        assert (pixel_rgb === ref_pal[exp]) else report_mismatch($sformatf(
          "pixel (%0d,%0d) rgb %h, expected %h", ex, ey, pixel_rgb, ref_pal[exp]));
        assert (pixel_opaque === (exp != 8'h0F)) else report_mismatch($sformatf(
          "pixel (%0d,%0d) opaque flag %b is wrong", ex, ey, pixel_opaque));
        checked++;
        if (exp == 8'h0F) begin
          clear_seen++;
        end
      end
    end
    assert (u_tile_layer_top.u_tile_line_scanner.u_tile_layer_props.violations == 0)
      else report_problem("a scanner property failed");
  end

  initial begin
    seed      = 32'h2025;
    rst       = 1'b1;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    repeat (4) begin
      @(posedge clk);
      #1;
      assert (!pixel_valid && !gfx_rom_cs)
        else report_problem("pixel_valid or gfx_rom_cs active during reset");
    end
    rst = 1'b0;
    @(posedge clk);
    #1;
    assert (!pixel_valid && !gfx_rom_cs)
      else report_problem("pixel_valid or gfx_rom_cs active before the first line");
    load_map();
    load_palette(0);
    cpu_write(11'h400, 16'd0);
    cpu_write(11'h401, 16'd0);
    check_from = frame_count + 2;
    wait_frame(check_from + 1);
    // fine scroll close to the 512 wrap
    cpu_write(11'h400, 16'd507);
    cpu_write(11'h401, 16'd509);
    wait_frame(frame_count + 2);
    // written in mid-frame, seen from the next frame on
    wait_line(9'd2);
    cpu_write(11'h400, 16'd37);
    cpu_write(11'h401, 16'd203);
    wait_frame(frame_count + 2);
    cpu_write(11'h400, 16'd511);
    cpu_write(11'h401, 16'd511);
    wait_frame(frame_count + 2);
    // new palette during vblank
    wait_line(9'd5);
    load_palette(16'h5A3);
    wait_frame(frame_count + 2);
    if (checked > 4096 && clear_seen > 0 && clear_seen < checked) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_problem("too few pixels checked, or no mix of clear and opaque pixels");
    end
  end

endmodule

// File: tile_layer_top.f
hdl/tile_layer_pkg.sv
hdl/video_timing_pkg.sv
hdl/video_timing.sv
hdl/layer_cpu_if.sv
hdl/tile_map_ram.sv
hdl/tile_line_scanner.sv
hdl/palette_out.sv
hdl/tile_layer_top.sv
bench/tile_layer_props.sv
bench/tile_layer_tb.sv
